/* rvFrontPkg.sv */
package rvFrontPkg;

    // datapath width, RV32I only
    localparam int xlen = 32;

    // instruction ROM geometry
    localparam int imemDepth    = 256;  // words
    localparam int imemAddrBits = 8;    // word index width

    // plain vectors with a meaning
    typedef logic [xlen-1:0] word_t;    // instruction, pc or immediate
    typedef logic [4:0]      regIdx_t;  // x0..x31
    typedef logic [6:0]      opcode_t;  // instr[6:0]

    // first fetch after reset
    localparam word_t resetPc = '0;

    // base opcodes seen by the front end
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opBranch = 7'b1100011;  // beq/bne/blt/...
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;
    localparam opcode_t opImm    = 7'b0010011;  // addi, slli, ...
    localparam opcode_t opReg    = 7'b0110011;  // add, sub, ... no immediate

    // immediate layouts, U format not handled here
    typedef enum logic [2:0] {
        immI,     // loads, alu immediates
        immS,     // stores
        immB,     // conditional branches
        immJ,     // jal
        immNone   // register ops and anything unknown
    } immFmt_t;

endpackage

/* fetchDecodeIf.sv */
interface fetchDecodeIf import rvFrontPkg::*; ();

    // contents of the IF/ID pipeline register
    logic  valid;    // live instruction, cleared on flush
    word_t pc;       // address it was fetched from
    word_t instr;    // raw instruction word
    word_t pcPlus4;  // sequential successor

    // fetch owns the register
    modport fetch (
        output valid,
        output pc,
        output instr,
        output pcPlus4
    );

    // decode only looks
    modport decode (
        input valid,
        input pc,
        input instr,
        input pcPlus4
    );

endinterface

/* instrMem.sv */
module instrMem import rvFrontPkg::*; (
    input  word_t pc,     // byte address from fetch
    output word_t instr   // word at that address, no latency
);

    word_t rom [imemDepth];              // program words
    logic [imemAddrBits-1:0] wordIdx;

    // program image comes from a hex file, one word per line
    initial begin
        $readmemh("frontProgram.hex", rom);
    end

    // byte address to word index, pc[9:2]
    // upper bits dropped so an out of range pc wraps
    assign wordIdx = pc[imemAddrBits+1:2];

    always_comb begin
        instr = rom[wordIdx];   // async read
    end

    // low two bits are ignored above, so a misaligned pc would silently
    // fetch the enclosing word
    always_comb begin
        assert final ($isunknown(pc) || pc[1:0] == 2'b00)
        else $error("instrMem misaligned fetch address %h", pc);
    end

endmodule

/* fetchStage.sv */
module fetchStage import rvFrontPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  stall,           // hold pc and IF/ID
    input  logic  redirect,        // taken branch from execute
    input  word_t redirectTarget,
    input  logic  jumpTaken,       // jal seen in decode
    input  word_t jumpTarget,
    input  word_t instr,           // from instrMem
    output word_t pc,              // to instrMem
    fetchDecodeIf.fetch ifId
);

    word_t pcPlus4;
    word_t pcNext;
    logic  flush;   // kill whatever is being fetched now

    assign pcPlus4 = pc + 32'd4;
    assign flush   = redirect | jumpTaken;

    // next pc, execute redirect beats decode jump beats stall
    always_comb begin
        if (redirect) begin
            pcNext = redirectTarget;
        end else if (jumpTaken) begin
            pcNext = jumpTarget;
        end else if (stall) begin
            pcNext = pc;            // freeze
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;
        end
    end

    // IF/ID valid bit, flush first then stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifId.valid <= 1'b0;
        end else if (flush) begin
            ifId.valid <= 1'b0;     // one bubble into decode
        end else if (!stall) begin
            ifId.valid <= 1'b1;
        end
    end

    // IF/ID payload, only meaningful while valid
    always_ff @(posedge clk) begin
        if (!flush && !stall) begin
            ifId.pc      <= pc;
            ifId.instr   <= instr;
            ifId.pcPlus4 <= pcPlus4;
        end
    end

    // targets from decode and execute must keep fetch word aligned
    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned %h", pc);

endmodule

/* immExtend.sv */
module immExtend import rvFrontPkg::*; (
    input  word_t instr,
    output word_t imm     // sign extended, zero for immNone
);

    opcode_t opcode;
    immFmt_t fmt;

    assign opcode = instr[6:0];

    // opcode to layout
    always_comb begin
        case (opcode)
            opImm, opLoad: fmt = immI;
            opStore:       fmt = immS;
            opBranch:      fmt = immB;
            opJal:         fmt = immJ;
            opReg:         fmt = immNone;   // rs2 form, nothing to extend
            default:       fmt = immNone;
        endcase
    end

    // standard RV32I scatter, instr[31] is always the sign
    always_comb begin
        case (fmt)
            immI: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            immS: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // split around rs2
            end
            immB: begin
                // bit 11 sits in instr[7]
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immJ: begin
                // +-1MiB range, halfword granular
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* decodeStage.sv */
module decodeStage import rvFrontPkg::*; (
    fetchDecodeIf.decode ifId,
    output logic    decValid,
    output word_t   decPc,
    output word_t   decInstr,
    output regIdx_t rd,
    output regIdx_t rs1,
    output regIdx_t rs2,
    output word_t   imm,
    output logic    isJump,      // opcode is jal, valid or not
    output logic    jumpTaken,   // back to fetch
    output word_t   jumpTarget
);

    opcode_t opcode;

    // pass the register contents through to execute side
    assign decValid = ifId.valid;
    assign decPc    = ifId.pc;
    assign decInstr = ifId.instr;

    assign opcode = ifId.instr[6:0];

    // fixed field positions for all formats
    assign rd  = ifId.instr[11:7];
    assign rs1 = ifId.instr[19:15];
    assign rs2 = ifId.instr[24:20];

    immExtend immExtend_i (
        .instr (ifId.instr),
        .imm   (imm)
    );

    // jal resolved here, costs one bubble instead of two
    assign isJump     = (opcode == opJal);
    assign jumpTaken  = ifId.valid && isJump;   // never act on a bubble
    assign jumpTarget = ifId.pc + imm;          // pc relative

    // fetch captured pc and its successor together
    always_comb begin
        assert final (ifId.valid !== 1'b1 || ifId.pcPlus4 == ifId.pc + 32'd4)
        else $error("IF/ID pcPlus4 %h does not follow pc %h", ifId.pcPlus4, ifId.pc);
    end

endmodule

/* rvFrontEnd.sv */
module rvFrontEnd import rvFrontPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,            // hazard hold, level
    input  logic    redirect,         // branch taken in execute, level
    input  word_t   redirectTarget,
    output logic    decValid,
    output word_t   decPc,
    output word_t   decInstr,
    output regIdx_t rd,
    output regIdx_t rs1,
    output regIdx_t rs2,
    output word_t   imm,
    output logic    isJump
);

    word_t fetchPc;      // fetch to rom
    word_t memInstr;     // rom back to fetch
    logic  jumpTaken;    // decode to fetch
    word_t jumpTarget;

    fetchDecodeIf ifId ();   // IF/ID register

    instrMem instrMem_i (
        .pc    (fetchPc),
        .instr (memInstr)
    );

    fetchStage fetchStage_i (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .jumpTaken      (jumpTaken),
        .jumpTarget     (jumpTarget),
        .instr          (memInstr),
        .pc             (fetchPc),
        .ifId           (ifId.fetch)
    );

    decodeStage decodeStage_i (
        .ifId       (ifId.decode),
        .decValid   (decValid),
        .decPc      (decPc),
        .decInstr   (decInstr),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm),
        .isJump     (isJump),
        .jumpTaken  (jumpTaken),
        .jumpTarget (jumpTarget)
    );

endmodule

/* rvFrontEnd_tb.sv */
module rvFrontEnd_tb import rvFrontPkg::*; ();

    localparam int clkHalf     = 4;    // 8 unit period
    localparam int resetCycles = 4;
    localparam int startLimit  = 16;   // cycles allowed until first live decode

    logic    clk;
    logic    rstN;
    logic    stall;
    logic    redirect;
    word_t   redirectTarget;
    logic    decValid;
    word_t   decPc;
    word_t   decInstr;
    regIdx_t rd;
    regIdx_t rs1;
    regIdx_t rs2;
    word_t   imm;
    logic    isJump;

    // fields of one golden line
    logic [31:0] inStall;
    logic [31:0] inRedirect;
    logic [31:0] inTarget;
    logic [31:0] expValid;
    logic [31:0] expPc;
    logic [31:0] expInstr;
    logic [31:0] expRd;
    logic [31:0] expRs1;
    logic [31:0] expImm;

    int    fd;
    int    scanCount;
    int    lineNo;            // data lines applied so far
    int    cycleCount = 0;    // rising edges since time zero
    string lineText;

    rvFrontEnd dut_i (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .decValid       (decValid),
        .decPc          (decPc),
        .decInstr       (decInstr),
        .rd             (rd),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .isJump         (isJump)
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h, cycle %0d, golden line %0d",
                     name, got, exp, cycleCount, lineNo);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // sample on falling edges until decode holds a live instruction
    task automatic waitFirstValid(input int maxCycles);
        int n;
        n = 0;
        @(negedge clk);
        while (decValid !== 1'b1) begin
            n++;
            if (n >= maxCycles)
                failRun("timeout: decValid never rose after reset");
            else
                @(negedge clk);
        end
    endtask

    // drive now, compare one clock later
    task automatic runGoldenLine();
        stall          = inStall[0];
        redirect       = inRedirect[0];
        redirectTarget = inTarget;
        @(negedge clk);
        checkEq("decValid", decValid, expValid);
        if (expValid[0]) begin      // payload of a bubble is stale
            checkEq("decPc", decPc, expPc);
            checkEq("decInstr", decInstr, expInstr);
            checkEq("rd", rd, expRd);
            checkEq("rs1", rs1, expRs1);
            checkEq("imm", imm, expImm);
            // rs2 field and jal flag taken from the expected word
            checkEq("rs2", rs2, expInstr[24:20]);
            checkEq("isJump", isJump, expInstr[6:0] == opJal);
        end
    endtask

    initial begin
        rstN           = 1'b0;
        stall          = 1'b0;
        redirect       = 1'b0;
        redirectTarget = '0;
        lineNo         = 0;

        fd = $fopen("rvFrontEnd_golden.txt", "r");
        if (fd == 0)
            failRun("cannot open rvFrontEnd_golden.txt");

        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        checkEq("decValid", decValid, 32'h0);   // nothing fetched yet
        waitFirstValid(startLimit);
        checkEq("decPc", decPc, resetPc);       // first live instr is the reset pc

        // decode now shows pc 0, golden lines pick up from here
        while (!$feof(fd)) begin
            if ($fgets(lineText, fd) > 0 && lineText.len() > 1 && lineText[0] != "#") begin
                lineNo++;
                scanCount = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h",
                                    inStall, inRedirect, inTarget, expValid, expPc,
                                    expInstr, expRd, expRs1, expImm);
                if (scanCount != 9)
                    failRun($sformatf("golden line %0d has %0d fields, 9 needed",
                                      lineNo, scanCount));
                else
                    runGoldenLine();
            end
        end
        $fclose(fd);

        stall    = 1'b0;
        redirect = 1'b0;
        if (lineNo == 0) begin
            failRun("golden file holds no stimulus lines");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* rvFrontEnd_golden.txt */
# stall redirect redirectTarget  decValid decPc decInstr rd rs1 imm   (all hex)
# one line per cycle, driven on a falling edge and checked on the next; payload unused when decValid is 0
0 0 00000000  1 00000004 ffd08113 02 01 fffffffd
0 0 00000000  1 00000008 fe20ae23 1c 01 fffffffc
0 0 00000000  1 0000000c fe20cce3 19 01 fffffff8
# stall for three cycles, blt stays in decode
1 0 00000000  1 0000000c fe20cce3 19 01 fffffff8
1 0 00000000  1 0000000c fe20cce3 19 01 fffffff8
1 0 00000000  1 0000000c fe20cce3 19 01 fffffff8
0 0 00000000  1 00000010 00114863 10 02 00000010
0 0 00000000  1 00000014 00100193 03 00 00000001
0 0 00000000  1 00000018 ff1ff0ef 01 1f fffffff0
# jal back to 0x08, one bubble
0 0 00000000  0 00000000 00000000 00 00 00000000
0 0 00000000  1 00000008 fe20ae23 1c 01 fffffffc
0 0 00000000  1 0000000c fe20cce3 19 01 fffffff8
0 0 00000000  1 00000010 00114863 10 02 00000010
0 0 00000000  1 00000014 00100193 03 00 00000001
0 0 00000000  1 00000018 ff1ff0ef 01 1f fffffff0
# execute redirect while jal sits in decode
0 1 00000020  0 00000000 00000000 00 00 00000000
0 0 00000000  1 00000020 fff00293 05 00 ffffffff
# redirect together with stall
1 1 00000000  0 00000000 00000000 00 00 00000000
0 0 00000000  1 00000000 00500093 01 00 00000005
0 0 00000000  1 00000004 ffd08113 02 01 fffffffd

/* frontProgram.hex */
// one instruction word per line, word address 0 first
00500093  // 00 addi x1, x0, 5
ffd08113  // 04 addi x2, x1, -3
fe20ae23  // 08 sw   x2, -4(x1)
fe20cce3  // 0c blt  x1, x2, -8
00114863  // 10 blt  x2, x1, 16
00100193  // 14 addi x3, x0, 1
ff1ff0ef  // 18 jal  x1, -16
00700213  // 1c addi x4, x0, 7
fff00293  // 20 addi x5, x0, -1
00502223  // 24 sw   x5, 4(x0)
00200313  // 28 addi x6, x0, 2
0000006f  // 2c jal  x0, 0

/* rvFrontEnd.f */
rvFrontPkg.sv
fetchDecodeIf.sv
instrMem.sv
fetchStage.sv
immExtend.sv
decodeStage.sv
rvFrontEnd.sv
rvFrontEnd_tb.sv
